//--- Bender.yml
package:
  name: rename_stage

sources:
  - src/rename_pkg.sv
  - src/rename_group_if.sv
  - src/free_list.sv
  - src/rename_table.sv
  - src/rename_logic.sv
  - src/dispatch_reg.sv
  - src/rename_top.sv
  - target: test
    files:
      - verif/rename_checker.sv
      - verif/rename_tb.sv

//--- flist.f
src/rename_pkg.sv
src/rename_group_if.sv
src/free_list.sv
src/rename_table.sv
src/rename_logic.sv
src/dispatch_reg.sv
src/rename_top.sv
verif/rename_checker.sv
verif/rename_tb.sv

//--- src/dispatch_reg.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_reg #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire logic                              stall,
    input  wire logic                              flush,
    rename_group_if.sink                           grp,
    output logic [FETCH_WIDTH-1:0]                 out_valid,
    output logic [FETCH_WIDTH-1:0]                 out_we,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]    out_rd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prs1,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prs2,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_old_prd,
    output rename_pkg::rob_ptr_t [FETCH_WIDTH-1:0] out_rob_idx
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else if (!stall) begin
            if (flush) begin
                out_valid <= '0;
            end else begin
                out_valid <= grp.valid; // Already low when the group was refused
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            out_we      <= grp.we;
            out_rd      <= grp.rd;
            out_prs1    <= grp.prs1;
            out_prs2    <= grp.prs2;
            out_prd     <= grp.prd;
            out_old_prd <= grp.old_prd;
            out_rob_idx <= grp.rob_idx;
        end
    end

endmodule

`default_nettype wire

//--- src/free_list.sv
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int PREG_COUNT  = rename_pkg::PREG_COUNT_DEF
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire rename_pkg::slot_cnt_t               pop_count,
    input  wire logic [FETCH_WIDTH-1:0]              push_valid,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] push_preg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      head_preg,
    output logic                                     full
);
    import rename_pkg::*;

    localparam int DEPTH = PREG_COUNT - AREG_COUNT;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    preg_t     mem [DEPTH];
    ptr_t      head;
    ptr_t      tail;
    cnt_t      count;
    slot_cnt_t push_off [FETCH_WIDTH];
    slot_cnt_t push_num;

    // Pointer step that wraps at DEPTH, which need not be a power of two
    function automatic ptr_t wrap_add(input ptr_t ptr, input int unsigned step);
        int unsigned sum;
        sum = ptr + step;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return ptr_t'(sum);
    endfunction

    // Valid pushes are packed together at the tail in slot order
    always_comb begin
        push_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            push_off[i] = push_num;
            push_num    = push_num + slot_cnt_t'(push_valid[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            head_preg[i] = mem[wrap_add(head, i)];
        end
    end

    assign full = (count < FETCH_WIDTH); // A whole group might need a register per slot

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= preg_t'(AREG_COUNT + i); // Registers above the identity map start free
            end
            head  <= '0;
            tail  <= '0;
            count <= cnt_t'(DEPTH);
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (push_valid[i]) begin
                    mem[wrap_add(tail, push_off[i])] <= push_preg[i];
                end
            end
            head  <= wrap_add(head, pop_count);
            tail  <= wrap_add(tail, push_num);
            count <= count + cnt_t'(push_num) - cnt_t'(pop_count);
        end
    end

endmodule

`default_nettype wire

//--- src/rename_group_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rename_group_if #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF
) ();
    import rename_pkg::*;

    logic [FETCH_WIDTH-1:0]     valid;
    logic [FETCH_WIDTH-1:0]     we;
    areg_t [FETCH_WIDTH-1:0]    rd;
    preg_t [FETCH_WIDTH-1:0]    prs1;
    preg_t [FETCH_WIDTH-1:0]    prs2;
    preg_t [FETCH_WIDTH-1:0]    prd;
    preg_t [FETCH_WIDTH-1:0]    old_prd; // Mapping of rd before this group
    rob_ptr_t [FETCH_WIDTH-1:0] rob_idx;

    modport source (
        output valid,
        output we,
        output rd,
        output prs1,
        output prs2,
        output prd,
        output old_prd,
        output rob_idx
    );

    modport sink (
        input valid,
        input we,
        input rd,
        input prs1,
        input prs2,
        input prd,
        input old_prd,
        input rob_idx
    );

endinterface

`default_nettype wire

//--- src/rename_logic.sv
`timescale 1ns/1ps
`default_nettype none

module rename_logic #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int ROB_DEPTH   = rename_pkg::ROB_DEPTH_DEF
) (
    input  wire logic [FETCH_WIDTH-1:0]              in_valid,
    input  wire logic [FETCH_WIDTH-1:0]              in_we,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rs1,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rs2,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rd,
    input  wire rename_pkg::rob_ptr_t                rob_tail,
    input  wire logic                                stall,
    input  wire logic                                flush,
    input  wire logic                                full,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] rs1_preg,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] rs2_preg,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] rd_preg,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] head_preg,
    output rename_pkg::slot_cnt_t                    pop_count,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]      rd_rs1,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]      rd_rs2,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]      rd_rd,
    output logic [FETCH_WIDTH-1:0]                   wr_en,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]      wr_areg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      wr_preg,
    rename_group_if.source                           grp
);
    import rename_pkg::*;

    localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

    logic                   accept;
    logic [FETCH_WIDTH-1:0] rd_en;
    logic [FETCH_WIDTH-1:0] raw_rs1 [FETCH_WIDTH]; // raw_rs1[i][j] is set when slot i reads the rd of older slot j
    logic [FETCH_WIDTH-1:0] raw_rs2 [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] waw [FETCH_WIDTH];     // waw[i][j] is set when younger slot j rewrites the rd of slot i
    slot_cnt_t              prd_idx [FETCH_WIDTH];
    slot_cnt_t              alloc_num;
    preg_t [FETCH_WIDTH-1:0]    prd;
    preg_t [FETCH_WIDTH-1:0]    prs1;
    preg_t [FETCH_WIDTH-1:0]    prs2;
    preg_t [FETCH_WIDTH-1:0]    old_prd;
    rob_ptr_t [FETCH_WIDTH-1:0] rob_idx;

    function automatic rob_ptr_t rob_add(input rob_ptr_t base, input int unsigned step);
        int unsigned sum;
        sum = base[ROB_IDX_W-1:0] + step;
        if (sum >= ROB_DEPTH) begin
            return {~base[ROB_IDX_W], ROB_IDX_W'(sum - ROB_DEPTH)}; // Crossed the end of the ROB
        end else begin
            return {base[ROB_IDX_W], ROB_IDX_W'(sum)};
        end
    endfunction

    assign accept = (|in_valid) & ~stall & ~flush & ~full;
    assign rd_en  = in_valid & in_we;

    assign rd_rs1 = in_rs1;
    assign rd_rs2 = in_rs2;
    assign rd_rd  = in_rd;

    // Each writer takes the next free register in slot order
    always_comb begin
        alloc_num = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            prd_idx[i] = alloc_num;
            prd[i]     = '0;
            if (rd_en[i]) begin
                prd[i] = head_preg[prd_idx[i]];
            end
            alloc_num = alloc_num + slot_cnt_t'(rd_en[i]);
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            for (int j = 0; j < FETCH_WIDTH; j++) begin
                raw_rs1[i][j] = (j < i) && rd_en[j] && (in_rs1[i] == in_rd[j]);
                raw_rs2[i][j] = (j < i) && rd_en[j] && (in_rs2[i] == in_rd[j]);
                waw[i][j]     = (j > i) && rd_en[i] && rd_en[j] && (in_rd[i] == in_rd[j]);
            end
        end
    end

    // Ascending scan so that the youngest older writer wins
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            prs1[i]    = rs1_preg[i];
            prs2[i]    = rs2_preg[i];
            old_prd[i] = rd_preg[i];
            for (int j = 0; j < FETCH_WIDTH; j++) begin
                if (raw_rs1[i][j]) begin
                    prs1[i] = prd[j];
                end
                if (raw_rs2[i][j]) begin
                    prs2[i] = prd[j];
                end
                if (waw[j][i]) begin
                    old_prd[i] = prd[j];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            wr_en[i]   = accept & rd_en[i] & ~(|waw[i]);
            rob_idx[i] = rob_add(rob_tail, i);
        end
    end

    assign pop_count = accept ? alloc_num : '0;
    assign wr_areg   = in_rd;
    assign wr_preg   = prd;

    assign grp.valid   = accept ? in_valid : '0;
    assign grp.we      = rd_en;
    assign grp.rd      = in_rd;
    assign grp.prs1    = prs1;
    assign grp.prs2    = prs2;
    assign grp.prd     = prd;
    assign grp.old_prd = old_prd;
    assign grp.rob_idx = rob_idx;

endmodule

`default_nettype wire

//--- src/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // Defaults for the module parameters of the rename stage
    localparam int FETCH_WIDTH_DEF = 4;
    localparam int PREG_COUNT_DEF  = 64;
    localparam int ROB_DEPTH_DEF   = 32; // Must stay a power of two

    localparam int AREG_COUNT = 32; // Fixed by the ISA

    localparam int AREG_W    = $clog2(AREG_COUNT);
    localparam int PREG_W    = $clog2(PREG_COUNT_DEF);
    localparam int ROB_PTR_W = $clog2(ROB_DEPTH_DEF) + 1; // Index plus wrap bit
    localparam int SLOT_CNT_W = $clog2(FETCH_WIDTH_DEF + 1);

    // Architectural register number
    typedef logic [AREG_W-1:0] areg_t;

    // Physical register number
    typedef logic [PREG_W-1:0] preg_t;

    // ROB index with the wrap bit on top
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

    // Number of slots, from 0 up to the full group
    typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

endpackage

`default_nettype wire

//--- src/rename_table.sv
`timescale 1ns/1ps
`default_nettype none

module rename_table #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_rs1,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_rs2,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] rd_rd,
    input  wire logic [FETCH_WIDTH-1:0]              wr_en,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] wr_areg,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] wr_preg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      rs1_preg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      rs2_preg,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      rd_preg
);
    import rename_pkg::*;

    preg_t map [AREG_COUNT];

    // Reads return the mapping from before this cycle's writes
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rs1_preg[i] = map[rd_rs1[i]];
            rs2_preg[i] = map[rd_rs2[i]];
            rd_preg[i]  = map[rd_rd[i]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < AREG_COUNT; r++) begin
                map[r] <= preg_t'(r);
            end
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (wr_en[i]) begin
                    map[wr_areg[i]] <= wr_preg[i]; // Later slot overrides an earlier one
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/rename_top.sv
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF,
    parameter int PREG_COUNT  = rename_pkg::PREG_COUNT_DEF,
    parameter int ROB_DEPTH   = rename_pkg::ROB_DEPTH_DEF
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [FETCH_WIDTH-1:0]              in_valid,
    input  wire logic [FETCH_WIDTH-1:0]              in_we,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rs1,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rs2,
    input  wire rename_pkg::areg_t [FETCH_WIDTH-1:0] in_rd,
    input  wire rename_pkg::rob_ptr_t                rob_tail,
    input  wire logic                                stall,
    input  wire logic                                flush,
    input  wire logic [FETCH_WIDTH-1:0]              commit_valid,
    input  wire rename_pkg::preg_t [FETCH_WIDTH-1:0] commit_preg,
    output logic [FETCH_WIDTH-1:0]                   out_valid,
    output logic [FETCH_WIDTH-1:0]                   out_we,
    output rename_pkg::areg_t [FETCH_WIDTH-1:0]      out_rd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      out_prs1,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      out_prs2,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      out_prd,
    output rename_pkg::preg_t [FETCH_WIDTH-1:0]      out_old_prd,
    output rename_pkg::rob_ptr_t [FETCH_WIDTH-1:0]   out_rob_idx,
    output logic                                     full
);
    import rename_pkg::*;

    slot_cnt_t               pop_count;
    preg_t [FETCH_WIDTH-1:0] head_preg;
    areg_t [FETCH_WIDTH-1:0] tbl_rs1;
    areg_t [FETCH_WIDTH-1:0] tbl_rs2;
    areg_t [FETCH_WIDTH-1:0] tbl_rd;
    preg_t [FETCH_WIDTH-1:0] rs1_preg;
    preg_t [FETCH_WIDTH-1:0] rs2_preg;
    preg_t [FETCH_WIDTH-1:0] rd_preg;
    logic [FETCH_WIDTH-1:0]  wr_en;
    areg_t [FETCH_WIDTH-1:0] wr_areg;
    preg_t [FETCH_WIDTH-1:0] wr_preg;

    rename_group_if #(.FETCH_WIDTH(FETCH_WIDTH)) group_if ();

    free_list #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .PREG_COUNT (PREG_COUNT)
    ) u_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .pop_count (pop_count),
        .push_valid(commit_valid),
        .push_preg (commit_preg),
        .head_preg (head_preg),
        .full      (full)
    );

    rename_table #(.FETCH_WIDTH(FETCH_WIDTH)) u_rename_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_rs1  (tbl_rs1),
        .rd_rs2  (tbl_rs2),
        .rd_rd   (tbl_rd),
        .wr_en   (wr_en),
        .wr_areg (wr_areg),
        .wr_preg (wr_preg),
        .rs1_preg(rs1_preg),
        .rs2_preg(rs2_preg),
        .rd_preg (rd_preg)
    );

    rename_logic #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .ROB_DEPTH  (ROB_DEPTH)
    ) u_rename_logic (
        .in_valid (in_valid),
        .in_we    (in_we),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_rd    (in_rd),
        .rob_tail (rob_tail),
        .stall    (stall),
        .flush    (flush),
        .full     (full),
        .rs1_preg (rs1_preg),
        .rs2_preg (rs2_preg),
        .rd_preg  (rd_preg),
        .head_preg(head_preg),
        .pop_count(pop_count),
        .rd_rs1   (tbl_rs1),
        .rd_rs2   (tbl_rs2),
        .rd_rd    (tbl_rd),
        .wr_en    (wr_en),
        .wr_areg  (wr_areg),
        .wr_preg  (wr_preg),
        .grp      (group_if.source)
    );

    dispatch_reg #(.FETCH_WIDTH(FETCH_WIDTH)) u_dispatch_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .grp        (group_if.sink),
        .out_valid  (out_valid),
        .out_we     (out_we),
        .out_rd     (out_rd),
        .out_prs1   (out_prs1),
        .out_prs2   (out_prs2),
        .out_prd    (out_prd),
        .out_old_prd(out_old_prd),
        .out_rob_idx(out_rob_idx)
    );

endmodule

`default_nettype wire

//--- verif/rename_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rename_checker #(
    parameter int FETCH_WIDTH = rename_pkg::FETCH_WIDTH_DEF
) (
    input wire logic                                   clk,
    input wire logic                                   rst_n,
    input wire logic [FETCH_WIDTH-1:0]                 out_valid,
    input wire logic [FETCH_WIDTH-1:0]                 out_we,
    input wire rename_pkg::areg_t [FETCH_WIDTH-1:0]    out_rd,
    input wire rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prs1,
    input wire rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prs2,
    input wire rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_prd,
    input wire rename_pkg::preg_t [FETCH_WIDTH-1:0]    out_old_prd,
    input wire rename_pkg::rob_ptr_t [FETCH_WIDTH-1:0] out_rob_idx,
    input wire logic                                   full
);
    import rename_pkg::*;

    typedef struct packed {
        logic [FETCH_WIDTH-1:0]     valid;
        logic [FETCH_WIDTH-1:0]     we;
        areg_t [FETCH_WIDTH-1:0]    rd;
        preg_t [FETCH_WIDTH-1:0]    prs1;
        preg_t [FETCH_WIDTH-1:0]    prs2;
        preg_t [FETCH_WIDTH-1:0]    prd;
        preg_t [FETCH_WIDTH-1:0]    old_prd;
        rob_ptr_t [FETCH_WIDTH-1:0] rob_idx;
        logic                       full;
    } group_t;

    group_t exp_q [$]; // One entry per clock edge, in edge order
    int     error_count = 0;
    int     check_count = 0;

    task automatic expect_group(
        input logic [FETCH_WIDTH-1:0]     valid,
        input logic [FETCH_WIDTH-1:0]     we,
        input areg_t [FETCH_WIDTH-1:0]    rd,
        input preg_t [FETCH_WIDTH-1:0]    prs1,
        input preg_t [FETCH_WIDTH-1:0]    prs2,
        input preg_t [FETCH_WIDTH-1:0]    prd,
        input preg_t [FETCH_WIDTH-1:0]    old_prd,
        input rob_ptr_t [FETCH_WIDTH-1:0] rob_idx,
        input logic                       full_exp
    );
        group_t g;
        g.valid   = valid;
        g.we      = we;
        g.rd      = rd;
        g.prs1    = prs1;
        g.prs2    = prs2;
        g.prd     = prd;
        g.old_prd = old_prd;
        g.rob_idx = rob_idx;
        g.full    = full_exp;
        exp_q.push_back(g);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    function automatic void compare_field(input string what, input logic [31:0] got,
                                          input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endfunction

    task automatic check_group(input group_t e);
        compare_field("full", full, e.full);
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            compare_field($sformatf("slot %0d valid", i), out_valid[i], e.valid[i]);
            if (e.valid[i]) begin
                compare_field($sformatf("slot %0d we", i), out_we[i], e.we[i]);
                compare_field($sformatf("slot %0d rd", i), out_rd[i], e.rd[i]);
                compare_field($sformatf("slot %0d prs1", i), out_prs1[i], e.prs1[i]);
                compare_field($sformatf("slot %0d prs2", i), out_prs2[i], e.prs2[i]);
                if (e.we[i]) begin
                    compare_field($sformatf("slot %0d prd", i), out_prd[i], e.prd[i]);
                    compare_field($sformatf("slot %0d old_prd", i), out_old_prd[i],
                                  e.old_prd[i]);
                end
            end
            if (|e.valid) begin
                compare_field($sformatf("slot %0d rob_idx", i), out_rob_idx[i], e.rob_idx[i]);
            end
        end
    endtask

    // The reset state is visible as soon as reset is released
    always @(posedge rst_n) begin
        compare_field("out_valid after reset", out_valid, 0);
        compare_field("full after reset", full, 0);
    end

    // Outputs have settled one ns after the edge that loaded them
    always @(posedge clk) begin
        #1;
        if (rst_n && exp_q.size() > 0) begin
            check_group(exp_q.pop_front());
        end
    end

endmodule

`default_nettype wire

//--- verif/rename_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rename_tb;
    import rename_pkg::*;

    localparam int          FETCH_WIDTH = FETCH_WIDTH_DEF;
    localparam int          CLK_PERIOD  = 20;
    localparam int          GROUP_COUNT = 40; // Random groups per phase
    localparam int          TIMEOUT     = 40; // In clock cycles
    localparam logic [31:0] SEED        = 32'he31d9b1d;

    typedef logic [FETCH_WIDTH-1:0] slot_mask_t;

    logic                       clk;
    logic                       rst_n;
    slot_mask_t                 in_valid;
    slot_mask_t                 in_we;
    areg_t [FETCH_WIDTH-1:0]    in_rs1;
    areg_t [FETCH_WIDTH-1:0]    in_rs2;
    areg_t [FETCH_WIDTH-1:0]    in_rd;
    rob_ptr_t                   rob_tail;
    logic                       stall;
    logic                       flush;
    slot_mask_t                 commit_valid;
    preg_t [FETCH_WIDTH-1:0]    commit_preg;
    slot_mask_t                 out_valid;
    slot_mask_t                 out_we;
    areg_t [FETCH_WIDTH-1:0]    out_rd;
    preg_t [FETCH_WIDTH-1:0]    out_prs1;
    preg_t [FETCH_WIDTH-1:0]    out_prs2;
    preg_t [FETCH_WIDTH-1:0]    out_prd;
    preg_t [FETCH_WIDTH-1:0]    out_old_prd;
    rob_ptr_t [FETCH_WIDTH-1:0] out_rob_idx;
    logic                       full;

    preg_t                      model_map [AREG_COUNT];
    preg_t                      model_free [$];
    preg_t                      history [$]; // Old mappings that commit may release
    slot_mask_t                 exp_valid;
    slot_mask_t                 exp_we;
    areg_t [FETCH_WIDTH-1:0]    exp_rd;
    preg_t [FETCH_WIDTH-1:0]    exp_prs1;
    preg_t [FETCH_WIDTH-1:0]    exp_prs2;
    preg_t [FETCH_WIDTH-1:0]    exp_prd;
    preg_t [FETCH_WIDTH-1:0]    exp_old_prd;
    rob_ptr_t [FETCH_WIDTH-1:0] exp_rob_idx;
    logic [31:0]                lfsr;
    int                         errs_before;
    int                         n;

    rename_top #(
        .FETCH_WIDTH(FETCH_WIDTH),
        .PREG_COUNT (PREG_COUNT_DEF),
        .ROB_DEPTH  (ROB_DEPTH_DEF)
    ) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_we       (in_we),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_rd       (in_rd),
        .rob_tail    (rob_tail),
        .stall       (stall),
        .flush       (flush),
        .commit_valid(commit_valid),
        .commit_preg (commit_preg),
        .out_valid   (out_valid),
        .out_we      (out_we),
        .out_rd      (out_rd),
        .out_prs1    (out_prs1),
        .out_prs2    (out_prs2),
        .out_prd     (out_prd),
        .out_old_prd (out_old_prd),
        .out_rob_idx (out_rob_idx),
        .full        (full)
    );

    rename_checker #(.FETCH_WIDTH(FETCH_WIDTH)) chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .out_valid  (out_valid),
        .out_we     (out_we),
        .out_rd     (out_rd),
        .out_prs1   (out_prs1),
        .out_prs2   (out_prs2),
        .out_prd    (out_prd),
        .out_old_prd(out_old_prd),
        .out_rob_idx(out_rob_idx),
        .full       (full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < count; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Low register numbers are favoured so that slots collide often
    function automatic areg_t rand_areg();
        if (take_bits(1) != 0) begin
            return areg_t'(take_bits(AREG_W));
        end
        return areg_t'(take_bits(2));
    endfunction

    function automatic rob_ptr_t near_wrap_tail();
        int unsigned idx;
        idx = ROB_DEPTH_DEF - 1 - take_bits(2);
        return rob_ptr_t'(idx + take_bits(1) * ROB_DEPTH_DEF);
    endfunction

    // Drives one cycle at the falling edge, runs the model and waits for the next falling edge
    task automatic drive_cycle(input slot_mask_t v, input slot_mask_t we, input logic st,
                               input logic fl, input rob_ptr_t tail, input int commit_mode);
        preg_t tmp_map [AREG_COUNT];
        preg_t new_preg;
        logic  accept;
        int    k;
        int    pick;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            in_rs1[i]       = rand_areg();
            in_rs2[i]       = rand_areg();
            in_rd[i]        = rand_areg();
            commit_valid[i] = 1'b0;
            commit_preg[i]  = '0;
            if (commit_mode != 0 && history.size() > 0
                && (commit_mode == 2 || take_bits(2) == 0)) begin
                pick            = take_bits(6) % history.size();
                commit_valid[i] = 1'b1;
                commit_preg[i]  = history[pick];
                history.delete(pick);
            end
        end
        in_valid = v;
        in_we    = we;
        rob_tail = tail;
        stall    = st;
        flush    = fl;

        tmp_map = model_map;
        k       = 0;
        accept  = (|v) && !st && !fl && (model_free.size() >= FETCH_WIDTH);
        if (!st) begin
            exp_valid = accept ? v : '0;
            exp_we    = v & we;
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                exp_rd[i]      = in_rd[i];
                exp_prs1[i]    = tmp_map[in_rs1[i]]; // Sources see older slots of the group
                exp_prs2[i]    = tmp_map[in_rs2[i]];
                exp_rob_idx[i] = rob_ptr_t'(tail + i);
                if (v[i] && we[i]) begin
                    new_preg          = (k < model_free.size()) ? model_free[k] : '0;
                    exp_old_prd[i]    = tmp_map[in_rd[i]];
                    exp_prd[i]        = new_preg;
                    tmp_map[in_rd[i]] = new_preg;
                    k++;
                end
            end
        end
        if (accept) begin
            model_map = tmp_map;
            for (int i = 0; i < k; i++) begin
                void'(model_free.pop_front());
            end
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                if (v[i] && we[i]) begin
                    history.push_back(exp_old_prd[i]);
                end
            end
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (commit_valid[i]) begin
                model_free.push_back(commit_preg[i]);
            end
        end
        chk.expect_group(exp_valid, exp_we, exp_rd, exp_prs1, exp_prs2, exp_prd, exp_old_prd,
                         exp_rob_idx, model_free.size() < FETCH_WIDTH);
        @(negedge clk);
    endtask

    task automatic report_phase(input int num, input string name);
        $display("Phase %0d, %s: %0d mismatches", num, name, chk.error_count - errs_before);
        errs_before = chk.error_count;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = '0;
        in_we        = '0;
        in_rs1       = '0;
        in_rs2       = '0;
        in_rd        = '0;
        rob_tail     = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        commit_valid = '0;
        commit_preg  = '0;
        exp_valid    = '0;
        exp_we       = '0;
        exp_rd       = '0;
        exp_prs1     = '0;
        exp_prs2     = '0;
        exp_prd      = '0;
        exp_old_prd  = '0;
        exp_rob_idx  = '0;
        lfsr         = SEED;
        errs_before  = 0;
        for (int r = 0; r < AREG_COUNT; r++) begin
            model_map[r] = preg_t'(r);
        end
        for (int p = AREG_COUNT; p < PREG_COUNT_DEF; p++) begin
            model_free.push_back(preg_t'(p));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        drive_cycle('0, '0, 1'b0, 1'b0, '0, 0);
        drive_cycle('1, '1, 1'b0, 1'b0, '0, 0); // Takes 32 onward
        report_phase(1, "reset state and first allocation");

        repeat (6) begin
            drive_cycle(slot_mask_t'(take_bits(FETCH_WIDTH)), slot_mask_t'(take_bits(FETCH_WIDTH)),
                        1'b0, 1'b0, rob_ptr_t'(take_bits(ROB_PTR_W)), 0);
        end
        report_phase(2, "bypass and table rules");

        repeat (GROUP_COUNT) begin
            drive_cycle(slot_mask_t'(take_bits(FETCH_WIDTH)), slot_mask_t'(take_bits(FETCH_WIDTH)),
                        take_bits(2) == 0, take_bits(3) == 0, rob_ptr_t'(take_bits(ROB_PTR_W)), 1);
        end
        report_phase(3, "stall and flush");

        n = 0;
        while (!full && n < TIMEOUT) begin
            drive_cycle('1, '1, 1'b0, 1'b0, rob_ptr_t'(take_bits(ROB_PTR_W)), 0);
            n++;
        end
        if (!full) begin
            $display("Timed out: full never rose while the free list was drained");
            $display("Test failed");
            $finish;
        end
        repeat (3) begin
            drive_cycle('1, slot_mask_t'(take_bits(FETCH_WIDTH)), 1'b0, 1'b0, '0, 0);
        end
        report_phase(4, "free list exhaustion");

        n = 0;
        while (full && n < TIMEOUT) begin
            drive_cycle('0, '0, 1'b0, 1'b0, '0, 2);
            n++;
        end
        if (full) begin
            $display("Timed out: full never fell after registers were committed");
            $display("Test failed");
            $finish;
        end
        repeat (GROUP_COUNT) begin
            drive_cycle(slot_mask_t'(take_bits(FETCH_WIDTH)), slot_mask_t'(take_bits(FETCH_WIDTH)),
                        1'b0, 1'b0, rob_ptr_t'(take_bits(ROB_PTR_W)), 1);
        end
        report_phase(5, "commit and reuse");

        repeat (GROUP_COUNT) begin
            drive_cycle('1, slot_mask_t'(take_bits(FETCH_WIDTH)), 1'b0, 1'b0,
                        near_wrap_tail(), 2);
        end
        report_phase(6, "ROB index wrap");

        n = 0;
        while (chk.pending_count() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (chk.pending_count() != 0) begin
            $display("Timed out: the checker still holds expected groups");
            $display("Test failed");
            $finish;
        end
        $display("Checks: %0d, errors: %0d", chk.check_count, chk.error_count);
        if (chk.error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
